// ==== source/cpu_cfg_pkg.sv ====
package cpu_cfg_pkg;

	// Datapath word
	localparam int word_w = 16;

	// Register file shape
	localparam int reg_count = 8;
	localparam int reg_addr_w = $clog2(reg_count);

	// Program memory, one instruction per word
	localparam int imem_depth = 64;
	localparam int pc_w = $clog2(imem_depth);

	// Register shown on the debug port
	localparam int debug_reg = 1;

endpackage

// ==== source/cpu_isa_pkg.sv ====
package cpu_isa_pkg;

	import cpu_cfg_pkg::*;

	////////////////////////////////////////
	// Field widths
	////////////////////////////////////////

	localparam int op_w = 4;
	localparam int imm_w = 6;
	// Spare low bits of the register form
	localparam int pad_w = word_w - op_w - 3 * reg_addr_w;

	////////////////////////////////////////
	// Opcodes
	////////////////////////////////////////

	localparam logic [op_w-1:0] op_add = 4'd0;
	localparam logic [op_w-1:0] op_sub = 4'd1;
	localparam logic [op_w-1:0] op_and = 4'd2;
	localparam logic [op_w-1:0] op_or = 4'd3;
	localparam logic [op_w-1:0] op_xor = 4'd4;
	localparam logic [op_w-1:0] op_addi = 4'd5;
	localparam logic [op_w-1:0] op_bnez = 4'd6;
	localparam logic [op_w-1:0] op_halt = 4'd15;

	// ALU function select
	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor
	} alu_op_e;

	// Register form: rd = rs1 op rs2
	typedef struct packed {
		logic [op_w-1:0] opcode;
		logic [reg_addr_w-1:0] rd;
		logic [reg_addr_w-1:0] rs1;
		logic [reg_addr_w-1:0] rs2;
		logic [pad_w-1:0] unused;
	} instr_reg_t;

	// Immediate form, used by ADDI and BNEZ
	typedef struct packed {
		logic [op_w-1:0] opcode;
		logic [reg_addr_w-1:0] rd;
		logic [reg_addr_w-1:0] rs1;
		logic signed [imm_w-1:0] imm;
	} instr_imm_t;

	// One fetched word, two ways to read it
	typedef union packed {
		instr_reg_t r;
		instr_imm_t i;
	} instr_u;

endpackage

// ==== source/regfile_if.sv ====
`timescale 1ns/1ps

interface regfile_if import cpu_cfg_pkg::*; ();

	// Write port
	logic we;
	logic [reg_addr_w-1:0] waddr;
	logic [word_w-1:0] wdata;

	// Read port 1
	logic [reg_addr_w-1:0] raddr1;
	logic [word_w-1:0] rdata1;

	// Read port 2
	logic [reg_addr_w-1:0] raddr2;
	logic [word_w-1:0] rdata2;

	// Register file side
	modport regs (
		input we,
		input waddr,
		input wdata,
		input raddr1,
		input raddr2,
		output rdata1,
		output rdata2
	);

	// Execute side
	modport core (
		output we,
		output waddr,
		output wdata,
		output raddr1,
		output raddr2,
		input rdata1,
		input rdata2
	);

endinterface

// ==== source/register_file.sv ====
`timescale 1ns/1ps

module register_file import cpu_cfg_pkg::*; (
	input logic clk,
	input logic rst,

	regfile_if.regs rf,

	output logic [word_w-1:0] debug_out
);

	// Register storage
	logic [word_w-1:0] regs [reg_count];

	////////////////////////////////////////
	// Write port
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			// All registers back to zero
			regs <= '{default: '0};
		end else if (rf.we && (rf.waddr != '0)) begin
			// Register 0 is never written
			regs[rf.waddr] <= rf.wdata;
		end
	end

	////////////////////////////////////////
	// Read ports
	////////////////////////////////////////

	// Address 0 forced to zero
	always_comb begin
		if (rf.raddr1 == '0) begin
			rf.rdata1 = '0;
		end else begin
			rf.rdata1 = regs[rf.raddr1];
		end
	end

	// Second port, same rule
	always_comb begin
		if (rf.raddr2 == '0) begin
			rf.rdata2 = '0;
		end else begin
			rf.rdata2 = regs[rf.raddr2];
		end
	end

	// Values stored before this edge
	// so no path from wdata to rdata

	// Debug mirror
	assign debug_out = regs[debug_reg];

endmodule

// ==== source/instr_mem.sv ====
`timescale 1ns/1ps

module instr_mem
	import cpu_cfg_pkg::*;
	import cpu_isa_pkg::*;
(
	input logic clk,

	// Program load port
	input logic prog_we,
	input logic [pc_w-1:0] prog_addr,
	input logic [word_w-1:0] prog_data,

	// Fetch port
	input logic [pc_w-1:0] pc,
	output instr_u instr
);

	// Program words, not reset
	logic [word_w-1:0] mem [imem_depth];

	// Load one word per clock
	always_ff @(posedge clk) begin
		if (prog_we) begin
			mem[prog_addr] <= prog_data;
		end
	end

	// Fetch is combinational
	// Word handed out as the union
	assign instr = instr_u'(mem[pc]);

endmodule

// ==== source/pc_unit.sv ====
`timescale 1ns/1ps

module pc_unit
	import cpu_cfg_pkg::*;
	import cpu_isa_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic run,

	// From execute
	input logic branch_taken,
	input logic signed [imm_w-1:0] branch_offset,
	input logic halt_req,

	output logic [pc_w-1:0] pc,
	output logic step,
	output logic halted
);

	logic [pc_w-1:0] pc_next;
	logic [pc_w-1:0] pc_delta;

	// Only gate on progress
	assign step = run && !halted;

	// Offset sign extended to pc width
	assign pc_delta = branch_taken ? pc_w'(branch_offset) : '0;

	// Relative to the next word, wraps around memory
	assign pc_next = pc + pc_w'(1) + pc_delta;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
			halted <= 1'b0;
		end else if (step) begin
			if (halt_req) begin
				// Stop here, pc stays on the HALT
				halted <= 1'b1;
			end else begin
				pc <= pc_next;
			end
		end
	end

endmodule

// ==== source/decoder.sv ====
`timescale 1ns/1ps

module decoder import cpu_isa_pkg::*; (
	input instr_u instr,

	output alu_op_e alu_op,
	output logic use_imm,
	output logic reg_write,
	output logic is_branch,
	output logic is_halt
);

	// Opcode sits in the same bits in both views

	always_comb begin
		// Unknown opcodes fall through as no-op
		alu_op = alu_add;
		use_imm = 1'b0;
		reg_write = 1'b0;
		is_branch = 1'b0;
		is_halt = 1'b0;

		case (instr.r.opcode)
			////////////////////////////////////////
			// Register forms
			////////////////////////////////////////
			op_add: begin
				alu_op = alu_add;
				reg_write = 1'b1;
			end
			op_sub: begin
				alu_op = alu_sub;
				reg_write = 1'b1;
			end
			op_and: begin
				alu_op = alu_and;
				reg_write = 1'b1;
			end
			op_or: begin
				alu_op = alu_or;
				reg_write = 1'b1;
			end
			op_xor: begin
				alu_op = alu_xor;
				reg_write = 1'b1;
			end

			////////////////////////////////////////
			// Immediate forms
			////////////////////////////////////////
			op_addi: begin
				alu_op = alu_add;
				use_imm = 1'b1;
				reg_write = 1'b1;
			end
			// Condition tested on rs1
			op_bnez: begin
				is_branch = 1'b1;
			end
			op_halt: begin
				is_halt = 1'b1;
			end
			default: begin
			end
		endcase
	end

endmodule

// ==== source/alu.sv ====
`timescale 1ns/1ps

module alu
	import cpu_cfg_pkg::*;
	import cpu_isa_pkg::*;
(
	input alu_op_e op,
	input logic [word_w-1:0] a,
	input logic [word_w-1:0] b,
	output logic [word_w-1:0] result
);

	// Carries and borrows are dropped
	always_comb begin
		case (op)
			alu_add: begin
				result = a + b;
			end
			alu_sub: begin
				result = a - b;
			end
			alu_and: begin
				result = a & b;
			end
			alu_or: begin
				result = a | b;
			end
			alu_xor: begin
				result = a ^ b;
			end
			// Unused encodings
			default: begin
				result = '0;
			end
		endcase
	end

endmodule

// ==== source/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit
	import cpu_cfg_pkg::*;
	import cpu_isa_pkg::*;
(
	input instr_u instr,
	input logic step,

	regfile_if.core rf,

	// To the program counter
	output logic branch_taken,
	output logic signed [imm_w-1:0] branch_offset,
	output logic halt_req
);

	alu_op_e alu_op;
	logic use_imm;
	logic reg_write;
	logic is_branch;
	logic is_halt;

	logic [word_w-1:0] imm_ext;
	logic [word_w-1:0] operand_b;
	logic [word_w-1:0] alu_result;

	////////////////////////////////////////
	// Decode and compute
	////////////////////////////////////////

	decoder i_decoder (
		.instr(instr),
		.alu_op(alu_op),
		.use_imm(use_imm),
		.reg_write(reg_write),
		.is_branch(is_branch),
		.is_halt(is_halt)
	);

	// Immediate sign extended to a full word
	assign imm_ext = {{(word_w - imm_w){instr.i.imm[imm_w-1]}}, instr.i.imm};

	// Second operand select
	assign operand_b = use_imm ? imm_ext : rf.rdata2;

	alu i_alu (
		.op(alu_op),
		.a(rf.rdata1),
		.b(operand_b),
		.result(alu_result)
	);

	// Register file access
	assign rf.raddr1 = instr.r.rs1;
	assign rf.raddr2 = instr.r.rs2;
	assign rf.waddr = instr.r.rd;
	assign rf.wdata = alu_result;
	// No write while paused or halted
	assign rf.we = reg_write && step;

	// Branch when rs1 is nonzero
	assign branch_taken = is_branch && (rf.rdata1 != '0);
	assign branch_offset = instr.i.imm;
	assign halt_req = is_halt;

endmodule

// ==== source/tiny_cpu.sv ====
`timescale 1ns/1ps

module tiny_cpu
	import cpu_cfg_pkg::*;
	import cpu_isa_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic run,

	// Program load
	input logic prog_we,
	input logic [pc_w-1:0] prog_addr,
	input logic [word_w-1:0] prog_data,

	output logic [word_w-1:0] debug_out,
	output logic halted
);

	logic [pc_w-1:0] pc;
	logic step;
	instr_u instr;
	logic branch_taken;
	logic signed [imm_w-1:0] branch_offset;
	logic halt_req;

	// Register file bus
	regfile_if rf_bus ();

	////////////////////////////////////////
	// Fetch
	////////////////////////////////////////

	pc_unit i_pc_unit (
		.clk(clk),
		.rst(rst),
		.run(run),
		.branch_taken(branch_taken),
		.branch_offset(branch_offset),
		.halt_req(halt_req),
		.pc(pc),
		.step(step),
		.halted(halted)
	);

	instr_mem i_instr_mem (
		.clk(clk),
		.prog_we(prog_we),
		.prog_addr(prog_addr),
		.prog_data(prog_data),
		.pc(pc),
		.instr(instr)
	);

	////////////////////////////////////////
	// Execute and write back
	////////////////////////////////////////

	exec_unit i_exec_unit (
		.instr(instr),
		.step(step),
		.rf(rf_bus.core),
		.branch_taken(branch_taken),
		.branch_offset(branch_offset),
		.halt_req(halt_req)
	);

	register_file i_register_file (
		.clk(clk),
		.rst(rst),
		.rf(rf_bus.regs),
		.debug_out(debug_out)
	);

endmodule

// ==== sim/tb_tiny_cpu.sv ====
`timescale 1ns/1ps

module tb_tiny_cpu
	import cpu_cfg_pkg::*;
	import cpu_isa_pkg::*;
();

	localparam int clk_period = 8;
	localparam int reset_cycles = 4;
	localparam int run_limit = 300;
	// Programs loaded or rerun over the whole session
	localparam int n_programs = 9;
	localparam int watchdog_ns =
		n_programs * (imem_depth + reset_cycles + 1 + run_limit) * clk_period + 2000;

	logic clk;
	logic rst;
	logic run;
	logic prog_we;
	logic [pc_w-1:0] prog_addr;
	logic [word_w-1:0] prog_data;
	logic [word_w-1:0] debug_out;
	logic halted;

	// Program image for both the loader and the model
	logic [15:0] prog [64];
	int prog_len;
	logic [31:0] lfsr_state = 32'h550a_04c5;
	int checks = 0;
	int errors = 0;

	tiny_cpu i_tiny_cpu (
		.clk(clk),
		.rst(rst),
		.run(run),
		.prog_we(prog_we),
		.prog_addr(prog_addr),
		.prog_data(prog_data),
		.debug_out(debug_out),
		.halted(halted)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	// Right shifting Galois form with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// One step per bit taken
	task automatic take_bits(input int n, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
	endtask

	task automatic check_value(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("ERROR [%s] expected 16'h%04h, actual 16'h%04h", name, expected, actual);
		end
	endtask

	task automatic apply_reset();
		@(negedge clk);
		rst = 1'b1;
		run = 1'b0;
		repeat (reset_cycles) @(negedge clk);
		rst = 1'b0;
	endtask

	// Unused words hold HALT with the address in the low bits
	task automatic clear_program();
		for (int a = 0; a < 64; a++) begin
			prog[a] = {4'hf, 6'd0, 6'(a)};
		end
		prog_len = 0;
	endtask

	task automatic put_reg(input logic [3:0] op, input int rd, input int rs1, input int rs2);
		prog[prog_len] = {op, 3'(rd), 3'(rs1), 3'(rs2), 3'b000};
		prog_len++;
	endtask

	task automatic put_imm(input logic [3:0] op, input int rd, input int rs1,
			input logic [5:0] imm);
		prog[prog_len] = {op, 3'(rd), 3'(rs1), imm};
		prog_len++;
	endtask

	// Whole memory written one word per clock before a reset
	task automatic load_program();
		for (int a = 0; a < 64; a++) begin
			@(negedge clk);
			prog_we = 1'b1;
			prog_addr = pc_w'(a);
			prog_data = prog[a];
		end
		@(negedge clk);
		prog_we = 1'b0;
		apply_reset();
	endtask

	task automatic run_until_halt(input string name);
		int cycles;
		cycles = 0;
		@(negedge clk);
		run = 1'b1;
		while (!halted && cycles < run_limit) begin
			@(negedge clk);
			cycles++;
		end
		run = 1'b0;
		if (!halted) begin
			errors++;
			$display("%s: the core did not halt within %0d cycles", name, run_limit);
		end
	endtask

	// Instruction set model returning register 1 at HALT
	function automatic logic [15:0] model_r1();
		logic [15:0] r [8];
		logic [15:0] w;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] res;
		int pc;
		int imm;
		logic wr;
		for (int i = 0; i < 8; i++) begin
			r[i] = '0;
		end
		pc = 0;
		for (int n = 0; n < run_limit; n++) begin
			w = prog[pc];
			a = (w[8:6] == 0) ? 16'h0000 : r[w[8:6]];
			b = (w[5:3] == 0) ? 16'h0000 : r[w[5:3]];
			imm = int'($signed(w[5:0]));
			wr = 1'b1;
			res = '0;
			case (w[15:12])
				4'd0: res = a + b;
				4'd1: res = a - b;
				4'd2: res = a & b;
				4'd3: res = a | b;
				4'd4: res = a ^ b;
				4'd5: res = a + 16'(imm);
				4'd15: return r[1];
				default: wr = 1'b0;
			endcase
			if (wr && w[11:9] != 0) begin
				r[w[11:9]] = res;
			end
			// Taken branch is relative to the next word
			if (w[15:12] == 4'd6 && a != 0) begin
				pc = (pc + 1 + imm) & 63;
			end else begin
				pc = (pc + 1) & 63;
			end
		end
		return r[1];
	endfunction

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	task automatic reset_defaults();
		apply_reset();
		check_value("reset debug_out", 16'h0000, debug_out);
		check_value("reset halted", 16'h0000, 16'(halted));
	endtask

	task automatic alu_operations();
		logic [3:0] ops [5];
		logic [31:0] a;
		logic [31:0] b;
		ops = '{op_add, op_sub, op_and, op_or, op_xor};
		for (int k = 0; k < 5; k++) begin
			take_bits(6, a);
			take_bits(6, b);
			clear_program();
			put_imm(op_addi, 2, 0, a[5:0]);
			put_imm(op_addi, 3, 0, b[5:0]);
			put_reg(ops[k], 1, 2, 3);
			put_reg(op_halt, 0, 0, 0);
			load_program();
			run_until_halt($sformatf("alu op %0d", ops[k]));
			check_value($sformatf("alu op %0d", ops[k]), model_r1(), debug_out);
		end
	endtask

	// Writes to r0 are lost
	task automatic zero_register();
		logic [31:0] v;
		take_bits(6, v);
		clear_program();
		put_imm(op_addi, 0, 0, v[5:0] | 6'd1);
		put_reg(op_add, 1, 0, 0);
		put_reg(op_halt, 0, 0, 0);
		load_program();
		run_until_halt("zero register");
		check_value("zero register", 16'h0000, debug_out);
	endtask

	task automatic branch_loop();
		logic [31:0] count;
		logic [31:0] imm;
		logic [15:0] expected;
		take_bits(4, count);
		take_bits(6, imm);
		if (count[3:0] == 0) begin
			count = 1;
		end
		clear_program();
		put_imm(op_addi, 2, 0, count[5:0]);
		// Loop body at word 1
		put_imm(op_addi, 1, 1, imm[5:0]);
		put_imm(op_addi, 2, 2, 6'h3f);
		put_imm(op_bnez, 0, 2, 6'h3d);
		put_reg(op_halt, 0, 0, 0);
		load_program();
		run_until_halt("branch loop");
		expected = 16'(count[3:0]) * {{10{imm[5]}}, imm[5:0]};
		check_value("branch loop", expected, debug_out);
	endtask

	task automatic pause_and_resume();
		logic [31:0] v;
		logic [15:0] paused_r1;
		clear_program();
		take_bits(6, v);
		put_imm(op_addi, 1, 0, v[5:0]);
		// r1 after three steps is the sum of both immediates
		paused_r1 = {{10{v[5]}}, v[5:0]};
		take_bits(6, v);
		put_imm(op_addi, 2, 0, v[5:0]);
		paused_r1 = paused_r1 + {{10{v[5]}}, v[5:0]};
		put_reg(op_add, 1, 1, 2);
		put_reg(op_sub, 1, 1, 2);
		put_reg(op_xor, 1, 1, 2);
		take_bits(6, v);
		put_imm(op_addi, 1, 1, v[5:0]);
		put_reg(op_halt, 0, 0, 0);
		load_program();
		// Three steps before run drops
		@(negedge clk);
		run = 1'b1;
		repeat (3) @(negedge clk);
		run = 1'b0;
		repeat (5) begin
			@(negedge clk);
			check_value("pause debug_out", paused_r1, debug_out);
			check_value("pause halted", 16'h0000, 16'(halted));
		end
		run_until_halt("pause");
		check_value("pause result", model_r1(), debug_out);
	endtask

	// Program from the pause test stays in memory
	task automatic reset_after_halt();
		check_value("halted before reset", 16'h0001, 16'(halted));
		apply_reset();
		check_value("reset after halt halted", 16'h0000, 16'(halted));
		check_value("reset after halt debug_out", 16'h0000, debug_out);
		run_until_halt("rerun");
		check_value("rerun result", model_r1(), debug_out);
	endtask

	////////////////////////////////////////
	// Sequence and watchdog
	////////////////////////////////////////

	initial begin
		rst = 1'b1;
		run = 1'b0;
		prog_we = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		reset_defaults();
		alu_operations();
		zero_register();
		branch_loop();
		pause_and_resume();
		reset_after_halt();
		$display("checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	initial begin
		#(watchdog_ns);
		$display("Watchdog expired after %0d ns, the tests did not finish", watchdog_ns);
		$display("TEST FAIL");
		$finish;
	end

endmodule

// ==== tiny_cpu.f ====
source/cpu_cfg_pkg.sv
source/cpu_isa_pkg.sv
source/regfile_if.sv
source/register_file.sv
source/instr_mem.sv
source/pc_unit.sv
source/decoder.sv
source/alu.sv
source/exec_unit.sv
source/tiny_cpu.sv
sim/tb_tiny_cpu.sv

// ==== Bender.yml ====
package:
  name: tiny_cpu

sources:
  # Packages first, the ISA package uses the sizes
  - source/cpu_cfg_pkg.sv
  - source/cpu_isa_pkg.sv
  - source/regfile_if.sv
  - source/register_file.sv
  - source/instr_mem.sv
  - source/pc_unit.sv
  - source/decoder.sv
  - source/alu.sv
  - source/exec_unit.sv
  - source/tiny_cpu.sv
  - target: test
    files:
      - sim/tb_tiny_cpu.sv
